//--- sim.f
+incdir+design
design/robotPkg.sv
design/quadChannel.sv
design/speedSampler.sv
design/beaconReceiver.sv
design/hostRegisters.sv
design/robotIo.sv
testbench/tbRobotIo.sv

//--- Makefile
# Verilator build and run of the robot sensor front end

VERILATOR ?= verilator
TOP       ?= tbRobotIo
FILELIST  ?= sim.f
BUILDDIR  ?= obj_dir
LOGFILE   ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# the log decides the result, the run itself always ends with $finish
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) | tee $(LOGFILE)
	@grep -qx '>>> PASS' $(LOGFILE)

clean:
	rm -rf $(BUILDDIR) $(LOGFILE)

//--- testbench/tbRobotIo.sv
`timescale 1ns/100ps
`include "robot_settings.svh"

module tbRobotIo
	import robotPkg::*;
();

	localparam int SPEED_WINDOWS = 6;
	localparam int BEACON_CHECKS = 100;
	localparam int RESET_CYCLES  = 8 + 17 * 2 + 8;
	localparam int SPEED_CYCLES  = (SPEED_WINDOWS + 1) * 128 + SPEED_WINDOWS * 8 + 2;
	localparam int DIR_CYCLES    = 4 * (48 + 2) + 2;
	localparam int BEACON_CYCLES = BEACON_CHECKS * (24 + 6) + 4;
	localparam int STATUS_CYCLES = 20 * 8;
	localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + SPEED_CYCLES + DIR_CYCLES
		+ BEACON_CYCLES + STATUS_CYCLES);

	// every synchronized input in one word as the model sees it
	typedef struct packed
	{
		encoderPins_t [`ROBOT_NUM_ENC-1:0] enc;
		logic                              step;
		logic                              turn;
		logic                              light;
		logic                              startIn;
		logic                              switchRight;
		logic                              switchLeft;
		logic                              boardId;
	} pinSample_t;

	logic                              CLOCK_50;
	logic                              reset;
	encoderPins_t [`ROBOT_NUM_ENC-1:0] encoders;
	encoderPins_t                      laserEncoder;
	logic                              laserSyncIn;
	logic                              laserSignN;
	logic                              switchLeft;
	logic                              switchRight;
	logic                              startIn;
	logic                              boardId;
	hostBus_t                          host;
	logic [`ROBOT_WORD_W-1:0]          readData;

	logic [31:0] lfsrState = 32'd95030;
	int          checkCount = 0;
	int          errorCount = 0;
	int          cycleCount = 0;

	// background stimulus state
	logic                      encActive = 1'b0;
	logic [`ROBOT_NUM_ENC-1:0] encReverse = '0;
	int                        encRate [`ROBOT_NUM_ENC] = '{default: 2};
	int                        encWait [`ROBOT_NUM_ENC] = '{default: 0};
	logic [1:0]                encPhase [`ROBOT_NUM_ENC] = '{default: 2'd0};
	logic                      beaconActive = 1'b0;
	logic                      lightOn = 1'b0;
	int                        beaconPhase = 0;
	int                        lightWait = 3;
	int                        syncWait = 8;

	// model state
	pinSample_t               hist1, hist2, hist3;   // hist1 is the newest sample
	logic [15:0]              mCountA [`ROBOT_NUM_ENC];
	logic [15:0]              mCountB [`ROBOT_NUM_ENC];
	logic [15:0]              mSpeed [`ROBOT_NUM_ENC];
	logic [`ROBOT_NUM_ENC-1:0] mDir;
	logic [`ROBOT_NUM_ENC-1:0] mInvert;
	logic [5:0]               mGlitch;
	logic [5:0]               mGap;
	logic [15:0]              mWindow, mAngle, mHold, mStart, mEnd;
	logic                     mDetected, mNewTurn;
	logic [15:0]              expRead;
	int                       mState;   // 0 idle, 1 receiving, 2 gap
	int                       mCycles;
	int                       windowsClosed = 0;
	int                       reflections = 0;
	int                       bridgedGaps = 0;

	robotIo uut (.CLOCK_50, .reset, .encoders, .laserEncoder, .laserSyncIn, .laserSignN,
		.switchLeft, .switchRight, .startIn, .boardId, .host, .readData);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	// ==================================================
	// random source and helpers
	// ==================================================
	function automatic logic [15:0] randomBits(input int count);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[14:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
		end
		return bits;
	endfunction

	// gray sequence where a leads going forward
	function automatic encoderPins_t quadPins(input logic [1:0] phase);
		case (phase)
			2'd0: return 2'b00;
			2'd1: return 2'b10;
			2'd2: return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	task automatic compareValue(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s read 0x%04h, expected 0x%04h", $time, what,
				actual, expected);
		end
	endtask

	// encoders and beacon keep moving while the host is busy
	task automatic nextCycle();
		@(posedge CLOCK_50);
		for (int i = 0; i < `ROBOT_NUM_ENC; i++)
		begin
			if (encActive && encWait[i] == 0)
			begin
				encPhase[i] = encReverse[i] ? encPhase[i] - 2'd1 : encPhase[i] + 2'd1;
				encoders[i] <= quadPins(encPhase[i]);
				encWait[i] = encRate[i] + int'(randomBits(2));
			end
			else if (encWait[i] > 0)
				encWait[i]--;
		end
		if (beaconActive)
		begin
			case (beaconPhase)   // step rise at 0, light moves at 2, sync at 4
				0: laserEncoder.a <= 1'b1;
				2:
				begin
					laserEncoder.b <= 1'b1;
					if (lightWait > 0)
						lightWait--;
					else
					begin
						lightOn = ~lightOn;
						laserSignN <= ~lightOn;
						if (lightOn)
							lightWait = int'(randomBits(2));
						else if (randomBits(1) != 0)
							lightWait = int'(randomBits(1));   // 1 or 2 steps dark
						else
							lightWait = 3 + int'(randomBits(3));
					end
				end
				4:
				begin
					laserEncoder.a <= 1'b0;
					if (syncWait > 0)
						syncWait--;
					else
					begin
						laserSyncIn <= 1'b1;
						syncWait = 16 + int'(randomBits(5));
					end
				end
				6:
				begin
					laserEncoder.b <= 1'b0;
					laserSyncIn    <= 1'b0;
				end
				default: ;
			endcase
			beaconPhase = (beaconPhase + 1) % 8;
		end
	endtask

	task automatic runCycles(input int count);
		repeat (count) nextCycle();
	endtask

	task automatic writeRegister(input logic [3:0] addr, input logic [15:0] data);
		nextCycle();
		host <= {1'b0, 1'b1, addr, data};
		nextCycle();
		host <= '0;
	endtask

	task automatic readRegister(input logic [3:0] addr);
		nextCycle();
		host <= {1'b1, 1'b0, addr, 16'h0000};
		nextCycle();
		host <= '0;
		@(negedge CLOCK_50);
		compareValue(readData, expRead, $sformatf("register %0d", addr));
	endtask

	// ==================================================
	// reference model stepped on every clock edge
	// ==================================================
	function automatic logic [15:0] modelRegister(input logic [3:0] addr, input pinSample_t lvl);
		case (int'(addr))
			`ROBOT_ADDR_FLAGS:
				return {6'b0, mNewTurn, mDetected, lvl.startIn, lvl.switchRight,
					lvl.switchLeft, mDir, lvl.boardId};
			`ROBOT_ADDR_SPEED0, `ROBOT_ADDR_SPEED0 + 1, `ROBOT_ADDR_SPEED0 + 2,
			`ROBOT_ADDR_SPEED0 + 3:
				return mSpeed[int'(addr) - `ROBOT_ADDR_SPEED0];
			`ROBOT_ADDR_BEACON_START: return mStart;
			`ROBOT_ADDR_BEACON_END:   return mEnd;
			`ROBOT_ADDR_WINDOW:       return mWindow;
			`ROBOT_ADDR_BEACON_CFG:   return {4'b0, mInvert, 2'b0, mGlitch};
			default:                  return 16'h0000;
		endcase
	endfunction

	always @(posedge CLOCK_50)
	begin : referenceModel
		pinSample_t  rise;
		pinSample_t  lvl;
		logic        restart;
		logic        closeNow;
		if (reset)
		begin
			hist1 = '0;
			hist2 = '0;
			hist3 = '0;
			for (int i = 0; i < `ROBOT_NUM_ENC; i++)
			begin
				mCountA[i] = '0;
				mCountB[i] = '0;
				mSpeed[i]  = '0;
			end
			{mDir, mInvert, mGap, mAngle, mHold, mStart, mEnd} = '0;
			{mDetected, mNewTurn, expRead} = '0;
			mGlitch = `ROBOT_GLITCH_DEFAULT;
			mWindow = `ROBOT_WINDOW_DEFAULT;
			mState  = 0;
			mCycles = 0;
		end
		else
		begin
			lvl  = hist2;                // two sync stages
			rise = hist2 & ~hist3;
			if (host.read)
				expRead = modelRegister(host.address, lvl);

			// speed window from reset release or the last window write
			restart  = host.write && int'(host.address) == `ROBOT_ADDR_WINDOW;
			mCycles  = restart ? 0 : mCycles + 1;
			closeNow = !restart && mCycles == int'(mWindow) * 16;
			for (int i = 0; i < `ROBOT_NUM_ENC; i++)
			begin
				if (closeNow)
					mSpeed[i] = 16'((int'(mCountA[i]) + int'(mCountB[i])) / 2);
				if (restart || closeNow)
				begin
					mCountA[i] = 16'(rise.enc[i].a);   // closing edge opens the next window
					mCountB[i] = 16'(rise.enc[i].b);
				end
				else
				begin
					mCountA[i] = mCountA[i] + 16'(rise.enc[i].a);
					mCountB[i] = mCountB[i] + 16'(rise.enc[i].b);
				end
				if (rise.enc[i].a)
					mDir[i] = lvl.enc[i].b ^ mInvert[i];
			end
			if (closeNow)
			begin
				mCycles = 0;
				windowsClosed++;
			end

			// reflection window uses the angle before this edge's step
			case (mState)
				0:
					if (lvl.light)
					begin
						mStart    = mAngle;
						mDetected = ~mDetected;
						mState    = 1;
						reflections++;
					end
				1:
					if (!lvl.light)
					begin
						mHold  = mAngle;
						mGap   = '0;
						mState = 2;
					end
				default:
					if (lvl.light)
					begin
						mState = 1;
						bridgedGaps++;
					end
					else if (mGap >= mGlitch)
					begin
						mEnd   = mHold;
						mState = 0;
					end
					else if (rise.step)
						mGap = mGap + 6'd1;
			endcase
			if (rise.turn)
			begin
				mAngle   = '0;
				mNewTurn = ~mNewTurn;
			end
			else if (rise.step)
				mAngle = mAngle + 16'd1;

			if (host.write && int'(host.address) == `ROBOT_ADDR_BEACON_CFG)
			begin
				mGlitch = host.writeData[5:0];
				mInvert = host.writeData[11:8];
			end
			if (restart)
				mWindow = host.writeData;

			hist3 = hist2;
			hist2 = hist1;
			hist1 = {encoders, laserEncoder.a, laserSyncIn, ~laserSignN, startIn,
				switchRight, switchLeft, boardId};
		end
	end

	// run limit
	always @(posedge CLOCK_50)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ==================================================
	// test sequence
	// ==================================================
	initial
	begin
		int          target;
		logic [15:0] cfgData;
		reset        = 1'b1;
		encoders     = '0;
		laserEncoder = '0;
		laserSyncIn  = 1'b0;
		laserSignN   = 1'b1;   // dark
		switchLeft   = 1'b0;
		switchRight  = 1'b0;
		startIn      = 1'b0;
		boardId      = 1'b0;
		host         = '0;
		repeat (4) @(posedge CLOCK_50);
		reset <= 1'b0;
		@(negedge CLOCK_50);
		compareValue(readData, 16'h0000, "readData after reset");

		// defaults after a write to a read-only address
		writeRegister(4'(`ROBOT_ADDR_BEACON_START), randomBits(16));
		for (int a = 0; a < 16; a++)
			readRegister(4'(a));

		// speed over 128-cycle windows
		encActive = 1'b1;
		writeRegister(4'(`ROBOT_ADDR_WINDOW), 16'd8);
		readRegister(4'(`ROBOT_ADDR_WINDOW));
		for (int w = 0; w < SPEED_WINDOWS; w++)
		begin
			for (int i = 0; i < `ROBOT_NUM_ENC; i++)
			begin
				encRate[i]    = 1 + int'(randomBits(3));
				encReverse[i] = randomBits(1) != 0;
			end
			target = windowsClosed + 1;
			while (windowsClosed < target)
				nextCycle();
			for (int i = 0; i < `ROBOT_NUM_ENC; i++)
				readRegister(4'(`ROBOT_ADDR_SPEED0 + i));
		end

		// direction forward then reverse, inverted and mixed
		for (int i = 0; i < `ROBOT_NUM_ENC; i++)
			encRate[i] = 1 + int'(randomBits(2));
		encReverse = '0;
		runCycles(48);
		readRegister(4'(`ROBOT_ADDR_FLAGS));
		encReverse = '1;
		runCycles(48);
		readRegister(4'(`ROBOT_ADDR_FLAGS));
		writeRegister(4'(`ROBOT_ADDR_BEACON_CFG), {4'h0, 4'hF, 2'b00, 6'd20});
		runCycles(48);
		readRegister(4'(`ROBOT_ADDR_FLAGS));
		encReverse = 4'(randomBits(4));
		runCycles(48);
		readRegister(4'(`ROBOT_ADDR_FLAGS));

		// beacon with glitchHold 3 and noise in the spare bits
		encActive = 1'b0;
		cfgData = randomBits(16);
		cfgData[5:0] = 6'd3;
		writeRegister(4'(`ROBOT_ADDR_BEACON_CFG), cfgData);
		readRegister(4'(`ROBOT_ADDR_BEACON_CFG));
		beaconActive = 1'b1;
		for (int n = 0; n < BEACON_CHECKS; n++)
		begin
			runCycles(8 + int'(randomBits(4)));
			readRegister(4'(`ROBOT_ADDR_BEACON_START));
			readRegister(4'(`ROBOT_ADDR_BEACON_END));
			readRegister(4'(`ROBOT_ADDR_FLAGS));
		end
		beaconActive = 1'b0;
		if (reflections < 2 || bridgedGaps == 0)
		begin
			errorCount++;
			$display("beacon stimulus too thin: %0d reflections and %0d bridged gaps",
				reflections, bridgedGaps);
		end

		// status levels read at random distances from the change
		for (int n = 0; n < 20; n++)
		begin
			nextCycle();
			{startIn, switchRight, switchLeft, boardId} <= 4'(randomBits(4));
			runCycles(int'(randomBits(2)));
			readRegister(4'(`ROBOT_ADDR_FLAGS));
		end

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- design/robotIo.sv
`timescale 1ns/100ps
`include "robot_settings.svh"

module robotIo
	import robotPkg::*;
(
	input  logic                               CLOCK_50,
	input  logic                               reset,
	input  encoderPins_t [`ROBOT_NUM_ENC-1:0]  encoders,     // prop L/R, odo L/R
	input  encoderPins_t                       laserEncoder,
	input  logic                               laserSyncIn,
	input  logic                               laserSignN,
	input  logic                               switchLeft,
	input  logic                               switchRight,
	input  logic                               startIn,
	input  logic                               boardId,
	input  hostBus_t                           host,
	output logic [`ROBOT_WORD_W-1:0]           readData
);

	logic [`ROBOT_NUM_ENC-1:0][`ROBOT_WORD_W-1:0] countA;
	logic [`ROBOT_NUM_ENC-1:0][`ROBOT_WORD_W-1:0] countB;
	logic [`ROBOT_NUM_ENC-1:0][`ROBOT_WORD_W-1:0] speed;
	logic [`ROBOT_NUM_ENC-1:0]                    direction;
	logic [`ROBOT_SYNC_STAGES-1:0][3:0]           miscSync;   // start, right, left, id
	logic [`ROBOT_WORD_W-1:0]                     startAngle;
	logic [`ROBOT_WORD_W-1:0]                     endAngle;
	logic [`ROBOT_WORD_W-1:0]                     windowLength;
	logic                                         windowRestart;
	logic                                         clearCounts;
	logic                                         detected;
	logic                                         newTurn;
	beaconCfg_t                                   beaconCfg;
	statusFlags_t                                 status;

	// ==================================================
	// encoder channels
	// ==================================================
	for (genvar i = 0; i < `ROBOT_NUM_ENC; i++)
	begin : gChannel
		quadChannel channel (.CLOCK_50, .reset, .pins(encoders[i]),
			.dirInvert(beaconCfg.dirInvert[i]), .clearCounts,
			.countA(countA[i]), .countB(countB[i]), .direction(direction[i]));
	end

	speedSampler sampler (.CLOCK_50, .reset, .windowLength, .windowRestart,
		.countA, .countB, .clearCounts, .speed);

	beaconReceiver beacon (.CLOCK_50, .reset, .laserEncoder, .laserSyncIn, .laserSignN,
		.glitchHold(beaconCfg.glitchHold), .startAngle, .endAngle, .detected, .newTurn);

	// switches, start and id go straight into the status word
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
			miscSync <= '0;
		else
			miscSync <= {miscSync[`ROBOT_SYNC_STAGES-2:0],
				{startIn, switchRight, switchLeft, boardId}};
	end

	always_comb
	begin
		status             = '0;
		status.boardId     = miscSync[`ROBOT_SYNC_STAGES-1][0];
		status.switchLeft  = miscSync[`ROBOT_SYNC_STAGES-1][1];
		status.switchRight = miscSync[`ROBOT_SYNC_STAGES-1][2];
		status.startIn     = miscSync[`ROBOT_SYNC_STAGES-1][3];
		status.direction   = direction;
		status.detected    = detected;
		status.newTurn     = newTurn;
	end

	hostRegisters registers (.CLOCK_50, .reset, .host, .status, .speed, .startAngle,
		.endAngle, .readData, .windowLength, .windowRestart, .beaconCfg);

endmodule

//--- design/hostRegisters.sv
`timescale 1ns/100ps
`include "robot_settings.svh"

module hostRegisters
	import robotPkg::*;
(
	input  logic                                         CLOCK_50,
	input  logic                                         reset,
	input  hostBus_t                                     host,
	input  statusFlags_t                                 status,
	input  logic [`ROBOT_NUM_ENC-1:0][`ROBOT_WORD_W-1:0] speed,
	input  logic [`ROBOT_WORD_W-1:0]                     startAngle,
	input  logic [`ROBOT_WORD_W-1:0]                     endAngle,
	output logic [`ROBOT_WORD_W-1:0]                     readData,
	output logic [`ROBOT_WORD_W-1:0]                     windowLength,
	output logic                                         windowRestart,
	output beaconCfg_t                                   beaconCfg
);

	hostWord_u                flagsWord;
	beaconCfg_t               cfgWrite;
	logic [`ROBOT_WORD_W-1:0] readMux;

	// ==================================================
	// configuration writes
	// ==================================================
	assign windowRestart = host.write && (host.address == `ROBOT_ADDR_W'(`ROBOT_ADDR_WINDOW));

	always_comb
	begin
		cfgWrite           = beaconCfg_t'(host.writeData);
		cfgWrite.spareLow  = '0;   // reserved bits read back as zero
		cfgWrite.spareHigh = '0;
	end

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			windowLength         <= `ROBOT_WORD_W'(`ROBOT_WINDOW_DEFAULT);
			beaconCfg            <= '0;
			beaconCfg.glitchHold <= `ROBOT_GLITCH_W'(`ROBOT_GLITCH_DEFAULT);
		end
		else if (windowRestart)
			windowLength <= host.writeData;
		else if (host.write && (host.address == `ROBOT_ADDR_W'(`ROBOT_ADDR_BEACON_CFG)))
			beaconCfg <= cfgWrite;
	end

	// ==================================================
	// read side
	// ==================================================
	assign flagsWord.flags = status;

	always_comb
	begin
		readMux = '0;   // unused addresses read zero
		case (host.address)
			`ROBOT_ADDR_W'(`ROBOT_ADDR_FLAGS):        readMux = flagsWord.raw;
			`ROBOT_ADDR_W'(`ROBOT_ADDR_BEACON_START): readMux = startAngle;
			`ROBOT_ADDR_W'(`ROBOT_ADDR_BEACON_END):   readMux = endAngle;
			`ROBOT_ADDR_W'(`ROBOT_ADDR_WINDOW):       readMux = windowLength;
			`ROBOT_ADDR_W'(`ROBOT_ADDR_BEACON_CFG):   readMux = beaconCfg;
			default:
			begin
				for (int i = 0; i < `ROBOT_NUM_ENC; i++)
					if (host.address == `ROBOT_ADDR_W'(`ROBOT_ADDR_SPEED0 + i))
						readMux = speed[i];
			end
		endcase
	end

	// data stays until the next read strobe
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
			readData <= '0;
		else if (host.read)
			readData <= readMux;
	end

endmodule

//--- design/beaconReceiver.sv
`timescale 1ns/100ps
`include "robot_settings.svh"

module beaconReceiver
	import robotPkg::*;
(
	input  logic                       CLOCK_50,
	input  logic                       reset,
	input  encoderPins_t               laserEncoder,
	input  logic                       laserSyncIn,
	input  logic                       laserSignN,
	input  logic [`ROBOT_GLITCH_W-1:0] glitchHold,
	output logic [`ROBOT_WORD_W-1:0]   startAngle,
	output logic [`ROBOT_WORD_W-1:0]   endAngle,
	output logic                       detected,
	output logic                       newTurn
);

	typedef enum logic [1:0] {IDLE, RECEIVING, GAP} beaconState_t;

	logic [`ROBOT_SYNC_STAGES-1:0] stepSync;
	logic [`ROBOT_SYNC_STAGES-1:0] turnSync;
	logic [`ROBOT_SYNC_STAGES-1:0] lightSync;   // inverted at the pin, high = light
	logic                          stepPrev;
	logic                          turnPrev;
	logic                          stepRise;
	logic                          turnRise;
	logic                          light;
	logic [`ROBOT_WORD_W-1:0]      angle;
	logic [`ROBOT_WORD_W-1:0]      angleHold;   // angle where the light last dropped
	logic [`ROBOT_GLITCH_W-1:0]    gapSteps;
	beaconState_t                  state;

	// ==================================================
	// input sync and turret angle
	// ==================================================
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			stepSync  <= '0;
			turnSync  <= '0;
			lightSync <= '0;
			stepPrev  <= 1'b0;
			turnPrev  <= 1'b0;
		end
		else
		begin
			stepSync  <= {stepSync[`ROBOT_SYNC_STAGES-2:0], laserEncoder.a};
			turnSync  <= {turnSync[`ROBOT_SYNC_STAGES-2:0], laserSyncIn};
			lightSync <= {lightSync[`ROBOT_SYNC_STAGES-2:0], ~laserSignN};
			stepPrev  <= stepSync[`ROBOT_SYNC_STAGES-1];
			turnPrev  <= turnSync[`ROBOT_SYNC_STAGES-1];
		end
	end

	assign stepRise = stepSync[`ROBOT_SYNC_STAGES-1] & ~stepPrev;
	assign turnRise = turnSync[`ROBOT_SYNC_STAGES-1] & ~turnPrev;
	assign light    = lightSync[`ROBOT_SYNC_STAGES-1];

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			angle   <= '0;
			newTurn <= 1'b0;
		end
		else if (turnRise)
		begin
			angle   <= '0;   // sync wins over a step in the same cycle
			newTurn <= ~newTurn;
		end
		else if (stepRise)
			angle <= angle + 1'b1;
	end

	// ==================================================
	// reflection window with glitch filter
	// ==================================================
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			state      <= IDLE;
			gapSteps   <= '0;
			detected   <= 1'b0;
			startAngle <= '0;
			endAngle   <= '0;
			angleHold  <= '0;
		end
		else
		begin
			case (state)
				IDLE:
					if (light)
					begin
						startAngle <= angle;
						detected   <= ~detected;
						state      <= RECEIVING;
					end
				RECEIVING:
					if (!light)
					begin
						angleHold <= angle;
						gapSteps  <= '0;
						state     <= GAP;
					end
				GAP:
					if (light)
						state <= RECEIVING;   // short dropout, same reflection
					else if (gapSteps >= glitchHold)
					begin
						endAngle <= angleHold;
						state    <= IDLE;
					end
					else if (stepRise)
						gapSteps <= gapSteps + 1'b1;
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

//--- design/speedSampler.sv
`timescale 1ns/100ps
`include "robot_settings.svh"

module speedSampler
(
	input  logic                                         CLOCK_50,
	input  logic                                         reset,
	input  logic [`ROBOT_WORD_W-1:0]                     windowLength,
	input  logic                                         windowRestart,
	input  logic [`ROBOT_NUM_ENC-1:0][`ROBOT_WORD_W-1:0] countA,
	input  logic [`ROBOT_NUM_ENC-1:0][`ROBOT_WORD_W-1:0] countB,
	output logic                                         clearCounts,
	output logic [`ROBOT_NUM_ENC-1:0][`ROBOT_WORD_W-1:0] speed
);

	localparam int TIMER_W = `ROBOT_WORD_W + `ROBOT_WINDOW_UNIT_LOG2;

	logic [TIMER_W-1:0]                          timer;
	logic [TIMER_W-1:0]                          windowEnd;
	logic                                        closing;
	logic [`ROBOT_NUM_ENC-1:0][`ROBOT_WORD_W:0]  pairSum;   // one extra bit for the carry

	// last cycle of the window is length * 16 - 1
	assign windowEnd   = {windowLength, {`ROBOT_WINDOW_UNIT_LOG2{1'b0}}} - 1'b1;
	assign closing     = (timer == windowEnd) & ~windowRestart;
	assign clearCounts = closing | windowRestart;

	always_comb
	begin
		for (int i = 0; i < `ROBOT_NUM_ENC; i++)
			pairSum[i] = {1'b0, countA[i]} + {1'b0, countB[i]};
	end

	// ==================================================
	// window timer and speed latch
	// ==================================================
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			timer <= '0;
			speed <= '0;
		end
		else if (windowRestart)
			timer <= '0;   // new length restarts the window
		else if (closing)
		begin
			timer <= '0;
			for (int i = 0; i < `ROBOT_NUM_ENC; i++)
				speed[i] <= pairSum[i][`ROBOT_WORD_W:1];   // half of A plus B
		end
		else
			timer <= timer + 1'b1;
	end

endmodule

//--- design/quadChannel.sv
`timescale 1ns/100ps
`include "robot_settings.svh"

module quadChannel
	import robotPkg::*;
(
	input  logic                     CLOCK_50,
	input  logic                     reset,
	input  encoderPins_t             pins,
	input  logic                     dirInvert,
	input  logic                     clearCounts,
	output logic [`ROBOT_WORD_W-1:0] countA,
	output logic [`ROBOT_WORD_W-1:0] countB,
	output logic                     direction
);

	encoderPins_t [`ROBOT_SYNC_STAGES-1:0] pinSync;    // [0] is the first stage
	encoderPins_t                          pinPrev;
	encoderPins_t                          pinNow;
	logic                                  riseA;
	logic                                  riseB;

	// ==================================================
	// synchronizer and edge detect
	// ==================================================
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			pinSync <= '0;
			pinPrev <= '0;
		end
		else
		begin
			pinSync <= {pinSync[`ROBOT_SYNC_STAGES-2:0], pins};
			pinPrev <= pinNow;
		end
	end

	assign pinNow = pinSync[`ROBOT_SYNC_STAGES-1];
	assign riseA  = pinNow.a & ~pinPrev.a;
	assign riseB  = pinNow.b & ~pinPrev.b;

	// direction sampled from b on each rising a
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
			direction <= 1'b0;
		else if (riseA)
			direction <= pinNow.b ^ dirInvert;
	end

	// ==================================================
	// edge counters, wrap on overflow
	// ==================================================
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			countA <= '0;
			countB <= '0;
		end
		else if (clearCounts)
		begin
			// an edge on the closing cycle opens the next window
			countA <= `ROBOT_WORD_W'(riseA);
			countB <= `ROBOT_WORD_W'(riseB);
		end
		else
		begin
			countA <= countA + `ROBOT_WORD_W'(riseA);
			countB <= countB + `ROBOT_WORD_W'(riseB);
		end
	end

endmodule

//--- design/robotPkg.sv
`include "robot_settings.svh"

package robotPkg;

	// one quadrature encoder, two lines
	typedef struct packed
	{
		logic a;
		logic b;
	} encoderPins_t;

	// ==================================================
	// status word, register 0 (bit 0 is boardId)
	// ==================================================
	typedef struct packed
	{
		logic [`ROBOT_WORD_W-`ROBOT_NUM_ENC-7:0] spare;     // always zero
		logic                                   newTurn;
		logic                                   detected;
		logic                                   startIn;
		logic                                   switchRight;
		logic                                   switchLeft;
		logic [`ROBOT_NUM_ENC-1:0]              direction;  // one per channel
		logic                                   boardId;
	} statusFlags_t;

	// register 0 is assembled as flags, shipped as a plain word
	typedef union packed
	{
		statusFlags_t             flags;
		logic [`ROBOT_WORD_W-1:0] raw;
	} hostWord_u;

	// host request, one cycle per strobe
	typedef struct packed
	{
		logic                     read;
		logic                     write;
		logic [`ROBOT_ADDR_W-1:0] address;
		logic [`ROBOT_WORD_W-1:0] writeData;
	} hostBus_t;

	// beacon and polarity configuration, register 9
	typedef struct packed
	{
		logic [3:0]                 spareHigh;
		logic [`ROBOT_NUM_ENC-1:0]  dirInvert;
		logic [1:0]                 spareLow;
		logic [`ROBOT_GLITCH_W-1:0] glitchHold;
	} beaconCfg_t;

endpackage

//--- design/robot_settings.svh
`ifndef ROBOT_SETTINGS_SVH
`define ROBOT_SETTINGS_SVH

// ==================================================
// widths and counts
// ==================================================
`define ROBOT_WORD_W            16
`define ROBOT_ADDR_W            4
`define ROBOT_NUM_ENC           4
`define ROBOT_SYNC_STAGES       2
`define ROBOT_GLITCH_W          6

// speed window, in units of 2**LOG2 clock cycles
`define ROBOT_WINDOW_UNIT_LOG2  4
`define ROBOT_WINDOW_DEFAULT    31250   // 500000 cycles, 10 ms at 50 MHz
`define ROBOT_GLITCH_DEFAULT    20      // turret encoder steps

// ==================================================
// host register map
// ==================================================
`define ROBOT_ADDR_FLAGS        0
`define ROBOT_ADDR_SPEED0       1       // one word per channel from here
`define ROBOT_ADDR_BEACON_START 5
`define ROBOT_ADDR_BEACON_END   6
`define ROBOT_ADDR_WINDOW       8
`define ROBOT_ADDR_BEACON_CFG   9

`endif
